//--- hdl/gpio_pkg.sv
//----------------------------------------
// GPIO shared definitions
// AHB codes, register offsets and the
// address-phase and write-port types
//----------------------------------------

package gpio_pkg;

  localparam int unsigned GPIO_W = 32;             // Pin count and register width

  // AHB transfer types, bit 1 marks an active transfer
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // AHB transfer sizes
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // Address bits 10:4 of the control registers
  localparam logic [6:0] REG_DIR_OFS   = 7'h40;    // Offset 0x400
  localparam logic [6:0] REG_IMASK_OFS = 7'h41;    // Offset 0x410

  // Bit positions inside the one-hot register select
  localparam int unsigned SEL_DOUT  = 0;
  localparam int unsigned SEL_DIR   = 1;
  localparam int unsigned SEL_IMASK = 2;

  // Register view of address bits 9:2
  typedef struct packed {
    logic [5:0] word_ofs;                          // Bits 9:4
    logic [1:0] pad;                               // Bits 3:2, not decoded
  } reg_word_t;

  // Address bits 9:2, bit mask for data byte writes or register offset
  typedef union packed {
    logic [7:0] lane_mask;
    reg_word_t  reg_word;
  } data_addr_u;

  // Registered address phase
  typedef struct packed {
    logic       valid;                             // Selected active transfer
    logic       write;
    logic       size_byte;
    logic [1:0] lane;                              // HADDR 1:0
    data_addr_u addr_hi;                           // HADDR 9:2
  } ahb_aphase_t;

  // Write port from the bus front end to the register block
  typedef struct packed {
    logic [2:0]        sel;                        // One-hot register select
    logic [GPIO_W-1:0] be_mask;                    // Per-bit write mask
    logic              en;
  } gpio_wr_t;

endpackage

//--- hdl/gpio_ahb_front.sv
//----------------------------------------
// GPIO AHB-Lite front end
// Address phase capture, register and
// write mask decode, read data mux
//----------------------------------------

`timescale 1ns/100ps

module gpio_ahb_front (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic                        HSEL_i,
  input  logic [10:0]                 HADDR_i,
  input  logic                        HWRITE_i,
  input  logic [1:0]                  HTRANS_i,
  input  logic [2:0]                  HSIZE_i,
  input  logic                        HREADY_i,
  input  logic [gpio_pkg::GPIO_W-1:0] dout_i,      // Data Out register
  input  logic [gpio_pkg::GPIO_W-1:0] dir_i,       // Direction register
  input  logic [gpio_pkg::GPIO_W-1:0] imask_i,     // Interrupt Mask register
  input  logic [gpio_pkg::GPIO_W-1:0] pin_i,       // Synchronised pad inputs
  output gpio_pkg::gpio_wr_t          wr_o,
  output logic [gpio_pkg::GPIO_W-1:0] HRDATA_o,
  output logic                        HREADYOUT_o,
  output logic                        HRESP_o
);

  import gpio_pkg::*;

  ahb_aphase_t       aphase_q;                     // Data-phase copy of the address phase
  logic              addr10_q;                     // HADDR 10, data or control space
  logic [3:0]        lanes_nxt;
  logic [3:0]        lanes_q;                      // Active byte lanes
  logic              active;
  logic              sel_dout;
  logic              sel_dir;
  logic              sel_imask;
  logic [GPIO_W-1:0] lane_bits;
  logic [GPIO_W-1:0] data_mask;
  logic [GPIO_W-1:0] be_mask;
  logic [GPIO_W-1:0] rd_word;

  //----------------------------------------
  // Address phase
  //----------------------------------------

  assign active = HSEL_i & ((HTRANS_i == HTRANS_NONSEQ) | (HTRANS_i == HTRANS_SEQ));

  // Byte lanes touched by the transfer, little endian
  always_comb
  begin
    case (HSIZE_i)
      HSIZE_BYTE: lanes_nxt = 4'b0001 << HADDR_i[1:0];
      HSIZE_HALF: lanes_nxt = HADDR_i[1] ? 4'b1100 : 4'b0011;
      HSIZE_WORD: lanes_nxt = 4'b1111;
      default:    lanes_nxt = 4'b1111;              // Wider sizes treated as word
    endcase
  end

  // Held while HREADY is low
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      aphase_q <= '0;
      addr10_q <= 1'b0;
      lanes_q  <= 4'b0000;
    end
    else if (HREADY_i)
    begin
      aphase_q.valid     <= active;
      aphase_q.write     <= HWRITE_i;
      aphase_q.size_byte <= (HSIZE_i == HSIZE_BYTE);
      aphase_q.lane      <= HADDR_i[1:0];
      aphase_q.addr_hi   <= HADDR_i[9:2];
      addr10_q           <= HADDR_i[10];
      lanes_q            <= lanes_nxt;
    end
  end

  //----------------------------------------
  // Data phase decode
  //----------------------------------------

  assign sel_dout  = ~addr10_q;                    // 0x000 to 0x3FF
  assign sel_dir   = ({addr10_q, aphase_q.addr_hi.reg_word.word_ofs} == REG_DIR_OFS);
  assign sel_imask = ({addr10_q, aphase_q.addr_hi.reg_word.word_ofs} == REG_IMASK_OFS);

  assign lane_bits = {{8{lanes_q[3]}}, {8{lanes_q[2]}}, {8{lanes_q[1]}}, {8{lanes_q[0]}}};

  // Byte access to data space carries its own bit mask in HADDR 9:2
  assign data_mask = aphase_q.size_byte ?
                     ({24'h000000, aphase_q.addr_hi.lane_mask} << {aphase_q.lane, 3'b000}) :
                     lane_bits;

  assign be_mask = sel_dout ? data_mask : lane_bits;

  always_comb
  begin
    wr_o.sel            = 3'b000;
    wr_o.sel[SEL_DOUT]  = sel_dout;
    wr_o.sel[SEL_DIR]   = sel_dir;
    wr_o.sel[SEL_IMASK] = sel_imask;
    wr_o.be_mask        = be_mask;
    wr_o.en             = aphase_q.valid & aphase_q.write & HREADY_i;  // Completes on HREADY
  end

  //----------------------------------------
  // Read data
  //----------------------------------------

  // Data space returns the pad value, output pins show what is driven
  always_comb
  begin
    if (sel_dout)
      rd_word = (pin_i & ~dir_i) | (dout_i & dir_i);
    else if (sel_dir)
      rd_word = dir_i;
    else if (sel_imask)
      rd_word = imask_i;
    else
      rd_word = '0;                                // Unmapped offset
  end

  assign HRDATA_o    = (aphase_q.valid & ~aphase_q.write) ? (rd_word & be_mask) : '0;
  assign HREADYOUT_o = 1'b1;                       // Zero wait state
  assign HRESP_o     = 1'b0;                       // Always OKAY

endmodule

//--- hdl/gpio_regs.sv
//----------------------------------------
// GPIO control registers
// Data Out, Direction and Interrupt Mask
// with per-bit masked writes
//----------------------------------------

`timescale 1ns/100ps

module gpio_regs (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  gpio_pkg::gpio_wr_t          wr_i,
  input  logic [gpio_pkg::GPIO_W-1:0] HWDATA_i,
  output logic [gpio_pkg::GPIO_W-1:0] dout_o,
  output logic [gpio_pkg::GPIO_W-1:0] dir_o,
  output logic [gpio_pkg::GPIO_W-1:0] imask_o
);

  import gpio_pkg::*;

  logic [GPIO_W-1:0] dout_q;                       // Pad output value
  logic [GPIO_W-1:0] dir_q;                        // 1 enables the pad driver
  logic [GPIO_W-1:0] imask_q;                      // 1 lets a pin raise the interrupt
  logic              wr_dout;
  logic              wr_dir;
  logic              wr_imask;

  // New bits where the mask is set, old bits elsewhere
  function automatic logic [GPIO_W-1:0] merge(
    input logic [GPIO_W-1:0] old_val,
    input logic [GPIO_W-1:0] wdata,
    input logic [GPIO_W-1:0] mask
  );
    return (wdata & mask) | (old_val & ~mask);
  endfunction

  //----------------------------------------
  // Write strobes
  //----------------------------------------

  assign wr_dout  = wr_i.en & wr_i.sel[SEL_DOUT];
  assign wr_dir   = wr_i.en & wr_i.sel[SEL_DIR];
  assign wr_imask = wr_i.en & wr_i.sel[SEL_IMASK];

  //----------------------------------------
  // Registers
  //----------------------------------------

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      dout_q  <= '0;
      dir_q   <= '0;                               // All pins start as inputs
      imask_q <= '0;
    end
    else
    begin
      if (wr_dout)
        dout_q <= merge(dout_q, HWDATA_i, wr_i.be_mask);
      if (wr_dir)
        dir_q <= merge(dir_q, HWDATA_i, wr_i.be_mask);
      if (wr_imask)
        imask_q <= merge(imask_q, HWDATA_i, wr_i.be_mask);
    end
  end

  assign dout_o  = dout_q;
  assign dir_o   = dir_q;
  assign imask_o = imask_q;

endmodule

//--- hdl/gpio_input_sync.sv
//----------------------------------------
// GPIO input synchroniser
// Two-flop pad sync and one-cycle
// input-change interrupt
//----------------------------------------

`timescale 1ns/100ps

module gpio_input_sync (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic [gpio_pkg::GPIO_W-1:0] GPIOIN_i,
  input  logic [gpio_pkg::GPIO_W-1:0] dir_i,
  input  logic [gpio_pkg::GPIO_W-1:0] imask_i,
  output logic [gpio_pkg::GPIO_W-1:0] pin_o,
  output logic                        irq_o
);

  import gpio_pkg::*;

  logic [GPIO_W-1:0] sync1_q;                      // First stage, may go metastable
  logic [GPIO_W-1:0] sync2_q;                      // Stable pin value
  logic [GPIO_W-1:0] last_q;                       // Previous stable value
  logic [GPIO_W-1:0] changed;
  logic              irq_nxt;
  logic              irq_q;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      sync1_q <= '0;
      sync2_q <= '0;
      last_q  <= '0;
    end
    else
    begin
      sync1_q <= GPIOIN_i;
      sync2_q <= sync1_q;
      last_q  <= sync2_q;
    end
  end

  // Only unmasked input pins count
  assign changed = sync2_q ^ last_q;
  assign irq_nxt = |(changed & imask_i & ~dir_i);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      irq_q <= 1'b0;
    else
      irq_q <= irq_nxt;                            // One cycle per toggle
  end

  assign pin_o = sync2_q;
  assign irq_o = irq_q;

endmodule

//--- hdl/ahb_gpio_top.sv
//----------------------------------------
// AHB-Lite GPIO slave, 32 pins
// Bus front end, control registers and
// input synchroniser
//----------------------------------------

`timescale 1ns/100ps

module ahb_gpio_top (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  input  logic                        HSEL_i,
  input  logic [10:0]                 HADDR_i,
  input  logic                        HWRITE_i,
  input  logic [1:0]                  HTRANS_i,
  input  logic [2:0]                  HSIZE_i,
  input  logic [gpio_pkg::GPIO_W-1:0] HWDATA_i,
  input  logic                        HREADY_i,
  output logic                        HREADYOUT_o,
  output logic                        HRESP_o,
  output logic [gpio_pkg::GPIO_W-1:0] HRDATA_o,
  input  logic [gpio_pkg::GPIO_W-1:0] GPIOIN_i,     // From pads
  output logic [gpio_pkg::GPIO_W-1:0] GPIOOUT_o,    // Pad output value
  output logic [gpio_pkg::GPIO_W-1:0] GPIOEN_o,     // Pad driver enable
  output logic                        GPIOINT_o     // Input change interrupt
);

  import gpio_pkg::*;

  gpio_wr_t          wr;                           // Front end to registers
  logic [GPIO_W-1:0] dout;
  logic [GPIO_W-1:0] dir;
  logic [GPIO_W-1:0] imask;
  logic [GPIO_W-1:0] pin;                          // Synchronised inputs

  gpio_ahb_front u_front (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HSEL_i      (HSEL_i),
    .HADDR_i     (HADDR_i),
    .HWRITE_i    (HWRITE_i),
    .HTRANS_i    (HTRANS_i),
    .HSIZE_i     (HSIZE_i),
    .HREADY_i    (HREADY_i),
    .dout_i      (dout),
    .dir_i       (dir),
    .imask_i     (imask),
    .pin_i       (pin),
    .wr_o        (wr),
    .HRDATA_o    (HRDATA_o),
    .HREADYOUT_o (HREADYOUT_o),
    .HRESP_o     (HRESP_o)
  );

  gpio_regs u_regs (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .wr_i     (wr),
    .HWDATA_i (HWDATA_i),
    .dout_o   (dout),
    .dir_o    (dir),
    .imask_o  (imask)
  );

  gpio_input_sync u_sync (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .GPIOIN_i (GPIOIN_i),
    .dir_i    (dir),
    .imask_i  (imask),
    .pin_o    (pin),
    .irq_o    (GPIOINT_o)
  );

  assign GPIOOUT_o = dout;
  assign GPIOEN_o  = dir;

endmodule

//--- verif/gpio_properties.sv
//----------------------------------------
// GPIO bus and pad assertions
// Bound to the AHB GPIO top level
//----------------------------------------

`timescale 1ns/100ps

module gpio_properties (
  input logic HCLK,
  input logic HRESETn,
  input logic HREADYOUT_o,
  input logic HRESP_o,
  input logic GPIOINT_o
);

  // Zero wait, always OKAY
  a_hreadyout: assert property (@(posedge HCLK) disable iff (!HRESETn) HREADYOUT_o)
    else $error("HREADYOUT_o went low");
  a_hresp: assert property (@(posedge HCLK) disable iff (!HRESETn) !HRESP_o)
    else $error("HRESP_o signalled an error");

  a_int_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn) GPIOINT_o |=> !GPIOINT_o)
    else $error("GPIOINT_o held high longer than one cycle");

endmodule

bind ahb_gpio_top gpio_properties u_props (
  .HCLK        (HCLK),
  .HRESETn     (HRESETn),
  .HREADYOUT_o (HREADYOUT_o),
  .HRESP_o     (HRESP_o),
  .GPIOINT_o   (GPIOINT_o)
);

//--- verif/gpio_checker.sv
//----------------------------------------
// GPIO response checker
// Compares DUT outputs with vector
// expectations, counts mismatches
//----------------------------------------

`timescale 1ns/100ps

module gpio_checker (
  input  logic        HCLK,
  input  logic        HRESETn,
  input  logic        chk_valid_i,               // One cycle per vector check
  input  logic [3:0]  chk_kind_i,
  input  logic [31:0] chk_exp_i,
  input  logic [31:0] hrdata_i,
  input  logic [31:0] gpio_out_i,
  input  logic [31:0] gpio_en_i,
  input  logic        gpio_int_i,
  output int          err_cnt_o
);

  localparam logic [3:0] K_READ   = 4'h1;
  localparam logic [3:0] K_PIN    = 4'h2;
  localparam logic [3:0] K_WR_OUT = 4'h3;
  localparam logic [3:0] K_WR_EN  = 4'h4;
  localparam int         WIN_LEN  = 6;
  localparam int         IRQ_IDX  = 3;            // Pulse cycle after the pin edge

  int   err_cnt = 0;
  int   win_idx = -1;                             // -1 when no window open
  logic win_exp = 1'b0;
  logic exp_int;

  task automatic report_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    err_cnt++;
  endtask

  // Negedge sampling, outputs settled
  always @(negedge HCLK)
  begin
    if (HRESETn)
    begin
      if (chk_valid_i)
      begin
        case (chk_kind_i)
          K_READ:   if (hrdata_i !== chk_exp_i) report_value("HRDATA_o", hrdata_i, chk_exp_i);
          K_WR_OUT: if (gpio_out_i !== chk_exp_i) report_value("GPIOOUT_o", gpio_out_i, chk_exp_i);
          K_WR_EN:  if (gpio_en_i !== chk_exp_i) report_value("GPIOEN_o", gpio_en_i, chk_exp_i);
          K_PIN:
          begin
            win_idx = 0;
            win_exp = chk_exp_i[0];
          end
          default: ;
        endcase
      end
      exp_int = (win_idx == IRQ_IDX) && win_exp;  // Low outside the pulse slot
      if (gpio_int_i !== exp_int)
      begin
        $display("ERROR at %0d ns: GPIOINT_o is %b, expected %b", $time, gpio_int_i, exp_int);
        err_cnt++;
      end
      if (win_idx >= 0)
        win_idx = (win_idx == WIN_LEN - 1) ? -1 : win_idx + 1;
    end
  end

  assign err_cnt_o = err_cnt;

endmodule

//--- verif/tb_ahb_gpio.sv
//----------------------------------------
// AHB GPIO testbench top
// Clock, reset, vector reader, AHB
// driver, watchdog and result summary
//----------------------------------------

`timescale 1ns/100ps

module tb_ahb_gpio;

  import gpio_pkg::*;

  localparam int MAX_VEC  = 64;
  localparam int RST_CYC  = 3;
  localparam int VEC_CYC  = 20;                    // Cycle budget per vector
  localparam int PIN_WAIT = 6;                     // Interrupt window length

  // Vector kinds
  localparam logic [3:0] K_READ   = 4'h1;
  localparam logic [3:0] K_PIN    = 4'h2;
  localparam logic [3:0] K_WR_OUT = 4'h3;          // Write, then check GPIOOUT
  localparam logic [3:0] K_WR_EN  = 4'h4;          // Write, then check GPIOEN
  localparam logic [3:0] K_END    = 4'hf;

  typedef struct packed {
    logic [3:0]  kind;
    logic [3:0]  size;
    logic [11:0] addr;
    logic [31:0] data;                             // Write data or pin value
    logic [31:0] exp;
  } vec_t;

  logic              HCLK;
  logic              HRESETn;
  logic              hsel;
  logic [10:0]       haddr;
  logic              hwrite;
  logic [1:0]        htrans;
  logic [2:0]        hsize;
  logic [GPIO_W-1:0] hwdata;
  logic              hready;
  logic              hreadyout;
  logic              hresp;
  logic [GPIO_W-1:0] hrdata;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_en;
  logic              gpio_int;

  logic              chk_valid;                    // Checker strobe, one cycle
  logic [3:0]        chk_kind;
  logic [31:0]       chk_exp;
  int                err_cnt;

  logic [83:0]       vec_mem [MAX_VEC];
  int                n_vec = 0;
  int                n_pass = 0;
  int                n_fail = 0;
  logic              loaded = 1'b0;
  int                cycle_cnt = 0;
  logic [31:0]       lfsr = 32'hb65f;

  ahb_gpio_top uut (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HSEL_i      (hsel),
    .HADDR_i     (haddr),
    .HWRITE_i    (hwrite),
    .HTRANS_i    (htrans),
    .HSIZE_i     (hsize),
    .HWDATA_i    (hwdata),
    .HREADY_i    (hready),
    .HREADYOUT_o (hreadyout),
    .HRESP_o     (hresp),
    .HRDATA_o    (hrdata),
    .GPIOIN_i    (gpio_in),
    .GPIOOUT_o   (gpio_out),
    .GPIOEN_o    (gpio_en),
    .GPIOINT_o   (gpio_int)
  );

  gpio_checker u_checker (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .chk_valid_i (chk_valid),
    .chk_kind_i  (chk_kind),
    .chk_exp_i   (chk_exp),
    .hrdata_i    (hrdata),
    .gpio_out_i  (gpio_out),
    .gpio_en_i   (gpio_en),
    .gpio_int_i  (gpio_int),
    .err_cnt_o   (err_cnt)
  );

  initial HCLK = 1'b0;
  always #2 HCLK = ~HCLK;                          // 4 ns period

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);                      // One step per bit
    end
  endtask

  task automatic idle_gap();
    int n;
    take_bits(2, n);
    repeat (n) @(posedge HCLK);                    // 0 to 3 idle cycles
  endtask

  task automatic strobe_check(input vec_t v);
    chk_valid <= 1'b1;
    chk_kind  <= v.kind;
    chk_exp   <= v.exp;
    @(posedge HCLK);
    chk_valid <= 1'b0;
  endtask

  //----------------------------------------
  // AHB transfer, optional HREADY stall
  //----------------------------------------

  task automatic bus_transfer(input vec_t v);
    int stall;
    idle_gap();
    take_bits(1, stall);
    @(posedge HCLK);                               // Address phase
    hsel   <= 1'b1;
    htrans <= HTRANS_NONSEQ;
    hwrite <= (v.kind != K_READ);
    hsize  <= v.size[2:0];
    haddr  <= v.addr[10:0];
    @(posedge HCLK);                               // Data phase
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwrite <= 1'b0;
    if (v.kind != K_READ)
      hwdata <= v.data;
    if (stall != 0)
    begin
      hready <= 1'b0;                              // One wait cycle from the bus
      @(posedge HCLK);
      hready <= 1'b1;
    end
    if (v.kind != K_READ)
      @(posedge HCLK);                             // Register takes the write here
    strobe_check(v);
  endtask

  task automatic pin_change(input vec_t v);
    idle_gap();
    @(posedge HCLK);
    gpio_in <= v.data;
    strobe_check(v);                               // Opens the interrupt window
    repeat (PIN_WAIT - 1) @(posedge HCLK);
  endtask

  //----------------------------------------
  // Main sequence
  //----------------------------------------

  initial
  begin
    vec_t v;
    int   errs_before;
    HRESETn   = 1'b0;
    hsel      = 1'b0;
    haddr     = '0;
    hwrite    = 1'b0;
    htrans    = 2'b00;
    hsize     = HSIZE_WORD;
    hwdata    = '0;
    hready    = 1'b1;
    gpio_in   = '0;
    chk_valid = 1'b0;
    chk_kind  = 4'h0;
    chk_exp   = '0;
    for (int i = 0; i < MAX_VEC; i++)
      vec_mem[i] = {K_END, 80'h0};                 // Unread entries end the list
    $readmemh("verif/gpio_vectors.hex", vec_mem);
    while (n_vec < MAX_VEC && vec_mem[n_vec][83:80] != K_END)
      n_vec++;
    loaded = 1'b1;
    repeat (RST_CYC) @(posedge HCLK);
    HRESETn <= 1'b1;
    for (int i = 0; i < n_vec; i++)
    begin
      v           = vec_t'(vec_mem[i]);
      errs_before = err_cnt;
      case (v.kind)
        K_PIN:                     pin_change(v);
        K_READ, K_WR_OUT, K_WR_EN: bus_transfer(v);
        default:
          $display("Vector %0d has an unknown kind %h", i, v.kind);
      endcase
      if (err_cnt == errs_before && v.kind inside {K_PIN, K_READ, K_WR_OUT, K_WR_EN})
      begin
        n_pass++;
        $display("Vector %0d kind %h addr %h exp %h: ok", i, v.kind, v.addr, v.exp);
      end
      else
      begin
        n_fail++;
        $display("Vector %0d kind %h addr %h exp %h: mismatch", i, v.kind, v.addr, v.exp);
      end
    end
    if (n_vec == 0)
      $display("No test vectors were read");
    $display("Totals: %0d vectors, %0d passed, %0d failed, %0d errors",
             n_vec, n_pass, n_fail, err_cnt);
    if (n_vec > 0 && n_fail == 0 && err_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // Watchdog
  always @(posedge HCLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (loaded && cycle_cnt > n_vec * VEC_CYC + RST_CYC)
    begin
      $display("Timeout: vectors did not finish within %0d cycles",
               n_vec * VEC_CYC + RST_CYC);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

endmodule

//--- verif/gpio_vectors.hex
// kind_size_addr_data_expected; kind 1 read, 2 pin set (exp 1 = pulse), 3 write + GPIOOUT, 4 write + GPIOEN
// size is HSIZE, addr is HADDR 10:0, data is write data or pin value, f ends the list
1_2_400_00000000_00000000
1_2_410_00000000_00000000
3_2_410_0000ff0f_00000000
1_2_410_00000000_0000ff0f
4_1_412_12345678_00000000
1_2_410_00000000_1234ff0f
1_1_410_00000000_0000ff0f
4_2_400_f0f000ff_f0f000ff
4_1_402_a5a50000_a5a500ff
1_2_400_00000000_a5a500ff
1_0_403_00000000_a5000000
3_2_000_12345678_12345678
3_0_03d_ffffffff_12345f78
3_0_3c3_00000000_02345f78
3_0_204_000000ff_02345ff9
3_2_000_cafef00d_cafef00d
2_0_000_00000100_00000001
1_2_000_00000000_80a4010d
1_0_3fd_00000000_00000100
2_0_000_00020100_00000000
2_0_000_00020101_00000000
1_2_420_00000000_00000000
1_2_7fc_00000000_00000000
3_2_420_ffffffff_cafef00d
4_2_7fc_ffffffff_a5a500ff
2_0_000_00020301_00000001
1_1_002_00000000_80a60000
4_2_400_00000000_00000000
1_2_000_00000000_00020301
f_0_000_00000000_00000000

//--- flist.f
hdl/gpio_pkg.sv
hdl/gpio_ahb_front.sv
hdl/gpio_regs.sv
hdl/gpio_input_sync.sv
hdl/ahb_gpio_top.sv
verif/gpio_properties.sv
verif/gpio_checker.sv
verif/tb_ahb_gpio.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AHB GPIO testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_ahb_gpio -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ahb_gpio > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass line missing from $LOG"
exit 1
